/* dcache.f */
verilog/dcache_geom_pkg.sv
verilog/dcache_bus_pkg.sv
verilog/dcache_frames.sv
verilog/dcache_ctrl.sv
verilog/dcache.sv
verification/dcache_checker.sv
verification/dcache_monitor.sv
verification/dcache_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator, run, then scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module dcache_tb -f dcache.f -o sim_dcache

./obj_dir/sim_dcache +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log; then
    exit 1
fi
exit 0

/* verification/dcache_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_tb
    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;
();

    localparam int TIMEOUT  = 200;  // cycles per wait
    localparam int RST_CYC  = 16;
    localparam int MAX_WAIT = 3;    // busy cycles per word, at most

    typedef enum logic [1:0] {OP_RD, OP_WR, OP_HALT} tb_op_t;

    typedef struct packed {
        tb_op_t op;
        word_t  addr;
        word_t  store;
        word_t  exp;  // load word, reads only
    } step_t;

    logic     CLK = 1'b0;
    logic     nRST;
    dp_req_t  dp_req;
    dp_rsp_t  dp_rsp;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    step_t  steps [$];
    string  names [$];
    string  cur_name;
    word_t  cur_exp;
    int     mismatches;
    int     timeouts;
    int     assert_fails;

    // behavioral memory, absent words read as their own address
    word_t  mem [word_t];
    logic   mem_busy;
    word_t  mem_load;
    int     wait_cnt;
    int     next_wait;
    logic   rand_wait;
    integer seed = 32'h3eea5049;

    always #2 CLK = ~CLK;

    dcache dut0 (
        .CLK     (CLK),
        .nRST    (nRST),
        .dp_req  (dp_req),
        .dp_rsp  (dp_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    dcache_monitor mon0 (
        .CLK       (CLK),
        .nRST      (nRST),
        .dp_req    (dp_req),
        .dp_rsp    (dp_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .test_name (cur_name),
        .exp_load  (cur_exp),
        .errors    (mismatches)
    );

    function automatic word_t mem_word(input addr_t a);
        word_t k;
        k = word_t'(a) >> 2;
        if (mem.exists(k)) return mem[k];
        return k << 2;
    endfunction

    assign mem_rsp = '{busy: mem_busy, load: mem_load};

    // busy for the next cycle, a word moves when busy is low
    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            mem.delete();
            mem_busy <= 1'b0;
            wait_cnt <= 0;
        end else if (mem_req.ren || mem_req.wen) begin
            if (!mem_busy) begin
                if (mem_req.wen) mem[word_t'(mem_req.addr) >> 2] = mem_req.store;
                next_wait = rand_wait ? int'({$random(seed)} % (MAX_WAIT + 1)) : 0;
                wait_cnt <= next_wait;
                mem_busy <= (next_wait != 0);
            end else begin
                wait_cnt <= wait_cnt - 1;
                mem_busy <= (wait_cnt > 1);
            end
        end
    end

    always @(negedge CLK) begin
        mem_load <= mem_word(mem_req.addr);  // address has settled by now
    end

    task automatic add_step(input string name, input tb_op_t op, input word_t addr,
                            input word_t store, input word_t exp);
        names.push_back(name);
        steps.push_back('{op: op, addr: addr, store: store, exp: exp});
    endtask

    // set 2 holds tags of 0x1010, 0x2010 and 0x3010
    task automatic build_table();
        add_step("read_miss_w0",  OP_RD,   32'h0000_1010, 32'h0,         32'h0000_1010);
        add_step("read_same_w1",  OP_RD,   32'h0000_1014, 32'h0,         32'h0000_1014);
        add_step("write_hit",     OP_WR,   32'h0000_1010, 32'ha5a5_0001, 32'h0);
        add_step("read_after_wh", OP_RD,   32'h0000_1010, 32'h0,         32'ha5a5_0001);
        add_step("write_miss",    OP_WR,   32'h0000_4028, 32'hdead_beef, 32'h0);
        add_step("read_after_wm", OP_RD,   32'h0000_4028, 32'h0,         32'hdead_beef);
        add_step("fill_way1",     OP_RD,   32'h0000_2010, 32'h0,         32'h0000_2010);
        add_step("write_b_w1",    OP_WR,   32'h0000_2014, 32'h1234_5678, 32'h0);
        add_step("evict_a",       OP_RD,   32'h0000_3010, 32'h0,         32'h0000_3010);
        add_step("reload_a",      OP_RD,   32'h0000_1010, 32'h0,         32'ha5a5_0001);
        add_step("reload_b",      OP_RD,   32'h0000_2014, 32'h0,         32'h1234_5678);
        add_step("reload_c",      OP_RD,   32'h0000_3010, 32'h0,         32'h0000_3010);
        add_step("write_e",       OP_WR,   32'h0000_5038, 32'h0bad_cafe, 32'h0);
        add_step("halt_flush",    OP_HALT, 32'h0,         32'h0,         32'h0);
    endtask

    task automatic wait_response(input string name, input logic for_flush);
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < TIMEOUT && !seen; n++) begin
            @(posedge CLK);
            seen = for_flush ? dp_rsp.flushed : dp_rsp.hit;
        end
        if (!seen) begin
            timeouts++;
            $display("step %s: the cache gave no %s within %0d cycles", name,
                     for_flush ? "flushed" : "hit", TIMEOUT);
        end
    endtask

    task automatic apply_step(input int i);
        cur_name     <= names[i];
        cur_exp      <= steps[i].exp;
        dp_req.ren   <= (steps[i].op == OP_RD);
        dp_req.wen   <= (steps[i].op == OP_WR);
        dp_req.halt  <= (steps[i].op == OP_HALT);
        dp_req.addr  <= addr_t'(steps[i].addr);
        dp_req.store <= steps[i].store;
        wait_response(names[i], steps[i].op == OP_HALT);
    endtask

    task automatic run_pass(input logic random_busy);
        dp_req    <= '0;
        nRST      <= 1'b0;
        rand_wait <= random_busy;
        repeat (RST_CYC) @(posedge CLK);
        nRST <= 1'b1;
        @(posedge CLK);
        foreach (steps[i]) apply_step(i);
        repeat (2) @(posedge CLK);  // flush compare settles
    endtask

    initial begin
        dp_req    = '0;
        nRST      = 1'b0;
        mem_busy  = 1'b0;
        mem_load  = '0;
        rand_wait = 1'b0;
        timeouts  = 0;
        build_table();
        @(posedge CLK);
        run_pass(1'b0);  // busy always low
        run_pass(1'b1);
        assert_fails = dut0.chk0.fails;
        $display("errors: %0d (mismatches %0d, timeouts %0d, assertions %0d)",
                 mismatches + timeouts + assert_fails, mismatches, timeouts, assert_fails);
        if (mismatches + timeouts + assert_fails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/dcache_monitor.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_monitor
    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  dp_req_t  dp_req,
    input  dp_rsp_t  dp_rsp,
    input  mem_req_t mem_req,
    input  mem_rsp_t mem_rsp,
    input  string    test_name,
    input  word_t    exp_load,   // from the stimulus table
    output int       errors
);

    word_t ref_mem [word_t];  // initial pattern plus every datapath write
    word_t bus_mem [word_t];  // words the cache wrote out
    logic  flush_seen;

    function automatic word_t key_of(input addr_t a);
        return word_t'(a) >> 2;
    endfunction

    function automatic word_t ref_word(input word_t k);
        return ref_mem.exists(k) ? ref_mem[k] : k << 2;
    endfunction

    task automatic compare(input string what, input word_t exp, input word_t act);
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s, %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    initial errors = 0;

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ref_mem.delete();
            bus_mem.delete();
            flush_seen <= 1'b0;
        end else begin
            if (dp_rsp.hit && dp_req.ren) begin
                compare("load vs reference", ref_word(key_of(dp_req.addr)), dp_rsp.load);
                compare("load vs table", exp_load, dp_rsp.load);
            end
            if (dp_rsp.hit && dp_req.wen) ref_mem[key_of(dp_req.addr)] = dp_req.store;
            if (mem_req.wen && !mem_rsp.busy) bus_mem[key_of(mem_req.addr)] = mem_req.store;
            // every written word must have reached memory
            if (dp_rsp.flushed && !flush_seen) begin
                flush_seen <= 1'b1;
                foreach (ref_mem[k]) begin
                    compare($sformatf("memory at %h", k << 2), ref_mem[k],
                            bus_mem.exists(k) ? bus_mem[k] : k << 2);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verification/dcache_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_checker
    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;
(
    input logic     CLK,
    input logic     nRST,
    input dp_req_t  dp_req,
    input dp_rsp_t  dp_rsp,
    input mem_req_t mem_req,
    input mem_rsp_t mem_rsp
);

    int   fails = 0;
    logic mem_active;

    assign mem_active = mem_req.ren || mem_req.wen;

    one_direction: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_req.ren && mem_req.wen))
    else begin
        fails++;
        $error("memory read and write active together");
    end

    held_while_busy: assert property (@(posedge CLK) disable iff (!nRST)
        mem_active && mem_rsp.busy |=> $stable(mem_req))
    else begin
        fails++;
        $error("memory request changed while busy was high");
    end

    flush_after_halt: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(dp_rsp.flushed) |-> $past(dp_req.halt))
    else begin
        fails++;
        $error("flushed raised without halt");
    end

    no_hit_in_transfer: assert property (@(posedge CLK) disable iff (!nRST)
        mem_active |-> !dp_rsp.hit)
    else begin
        fails++;
        $error("hit raised during a memory transfer");
    end

endmodule

bind dcache dcache_checker chk0 (
    .CLK     (CLK),
    .nRST    (nRST),
    .dp_req  (dp_req),
    .dp_rsp  (dp_rsp),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
);

`default_nettype wire

/* verilog/dcache.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache
    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  dp_req_t  dp_req,
    output dp_rsp_t  dp_rsp,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    frame_cmd_t       cmd;
    lookup_t          lookup;     // for the current request address
    frame_t           scan_frame;
    logic [IDX_W-1:0] scan_idx;
    way_t             scan_way;

    // FSM and bus sequencing
    dcache_ctrl ctrl0 (
        .CLK        (CLK),
        .nRST       (nRST),
        .dp_req     (dp_req),
        .dp_rsp     (dp_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .lookup     (lookup),
        .scan_frame (scan_frame),
        .cmd        (cmd),
        .scan_idx   (scan_idx),
        .scan_way   (scan_way)
    );

    // tags, data and LRU bits
    dcache_frames frames0 (
        .CLK         (CLK),
        .nRST        (nRST),
        .lookup_addr (dp_req.addr),
        .cmd         (cmd),
        .scan_idx    (scan_idx),
        .scan_way    (scan_way),
        .lookup      (lookup),
        .scan_frame  (scan_frame)
    );

endmodule

`default_nettype wire

/* verilog/dcache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_ctrl
    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;
(
    input  logic             CLK,
    input  logic             nRST,
    input  dp_req_t          dp_req,
    output dp_rsp_t          dp_rsp,
    output mem_req_t         mem_req,
    input  mem_rsp_t         mem_rsp,
    input  lookup_t          lookup,
    input  frame_t           scan_frame,
    output frame_cmd_t       cmd,
    output logic [IDX_W-1:0] scan_idx,
    output way_t             scan_way
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    logic [IDX_W:0] scan_q;  // {way, set}
    logic [IDX_W:0] scan_d;

    logic             access;      // read or write pending
    logic             ready;       // idle, not halting
    logic             last_frame;
    logic [BLK_W-1:0] beat;        // word of the current transfer

    assign access     = dp_req.ren || dp_req.wen;
    assign ready      = (state_q == IDLE) && !dp_req.halt;
    assign last_frame = &scan_q;
    assign scan_way   = scan_q[IDX_W];
    assign scan_idx   = scan_q[IDX_W-1:0];

    // second half of each two-word transfer
    assign beat = (state_q inside {WB2, LD2, FLUSH2}) ? '1 : '0;

    always_comb begin
        state_d = state_q;
        scan_d  = scan_q;
        case (state_q)
            IDLE: begin
                if (dp_req.halt) begin
                    state_d = SCAN;
                    scan_d  = '0;
                end else if (access && !lookup.hit) begin
                    state_d = lookup.victim.dirty ? WB1 : LD1;  // clean victim skips write-back
                end
            end
            WB1: begin
                if (!mem_rsp.busy) state_d = WB2;
            end
            WB2: begin
                if (!mem_rsp.busy) state_d = LD1;
            end
            LD1: begin
                if (!mem_rsp.busy) state_d = LD2;
            end
            LD2: begin
                if (!mem_rsp.busy) state_d = IDLE;  // retry now hits
            end
            SCAN: begin
                if (scan_frame.dirty) begin
                    state_d = FLUSH1;
                end else if (last_frame) begin
                    state_d = HALTED;
                end else begin
                    scan_d = scan_q + 1'b1;
                end
            end
            FLUSH1: begin
                if (!mem_rsp.busy) state_d = FLUSH2;
            end
            FLUSH2: begin
                if (!mem_rsp.busy) state_d = SCAN;  // frame is clean on return
            end
            HALTED: begin
                state_d = HALTED;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // memory request, steady while busy
    always_comb begin
        mem_req = '0;
        mem_req.addr.blkoff = beat;
        case (state_q)
            WB1, WB2: begin
                mem_req.wen      = 1'b1;
                mem_req.addr.tag = lookup.victim.tag;
                mem_req.addr.idx = dp_req.addr.idx;
                mem_req.store    = lookup.victim.data[beat];
            end
            LD1, LD2: begin
                mem_req.ren      = 1'b1;
                mem_req.addr.tag = dp_req.addr.tag;
                mem_req.addr.idx = dp_req.addr.idx;
            end
            FLUSH1, FLUSH2: begin
                mem_req.wen      = 1'b1;
                mem_req.addr.tag = scan_frame.tag;
                mem_req.addr.idx = scan_idx;
                mem_req.store    = scan_frame.data[beat];
            end
            default: begin
                mem_req.addr.blkoff = '0;
            end
        endcase
    end

    // frame commands
    always_comb begin
        cmd.op       = NONE;
        cmd.idx      = dp_req.addr.idx;
        cmd.way      = ~lookup.hit_way;  // not a use unless it names the hit way
        cmd.word_sel = dp_req.addr.blkoff;
        cmd.tag      = dp_req.addr.tag;
        cmd.data     = dp_req.store;
        case (state_q)
            IDLE: begin
                if (ready && access && lookup.hit) begin
                    cmd.way = lookup.hit_way;
                    if (dp_req.wen) cmd.op = WRITE_WORD;
                end
            end
            LD1, LD2: begin
                if (!mem_rsp.busy) begin
                    cmd.op       = FILL_WORD;
                    cmd.way      = lookup.victim_way;
                    cmd.word_sel = beat;
                    cmd.data     = mem_rsp.load;
                end
            end
            FLUSH2: begin
                if (!mem_rsp.busy) begin
                    cmd.op  = CLEAN;
                    cmd.idx = scan_idx;
                    cmd.way = scan_way;
                end
            end
            default: begin
                cmd.op = NONE;
            end
        endcase
    end

    always_comb begin
        dp_rsp.hit     = ready && access && lookup.hit;  // same cycle as request
        dp_rsp.load    = lookup.hit_word;
        dp_rsp.flushed = (state_q == HALTED);
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state_q <= IDLE;
            scan_q  <= '0;
        end else begin
            state_q <= state_d;
            scan_q  <= scan_d;
        end
    end

endmodule

`default_nettype wire

/* verilog/dcache_frames.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_frames
    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;
(
    input  logic             CLK,
    input  logic             nRST,
    input  addr_t            lookup_addr,
    input  frame_cmd_t       cmd,
    input  logic [IDX_W-1:0] scan_idx,
    input  way_t             scan_way,
    output lookup_t          lookup,
    output frame_t           scan_frame
);

    // state bits
    logic [NWAYS-1:0][NSETS-1:0] valid_q;
    logic [NWAYS-1:0][NSETS-1:0] dirty_q;
    logic [NSETS-1:0]            lru_q;    // way to evict next

    // tags and words
    logic [TAG_W-1:0]            tag_q  [NWAYS][NSETS];
    word_t [WORDS_PER_FRAME-1:0] data_q [NWAYS][NSETS];

    logic [NWAYS-1:0] way_hit;
    way_t             hit_way;
    logic             read_use;

    function automatic frame_t get_frame(input way_t w, input logic [IDX_W-1:0] i);
        frame_t f;
        f.valid = valid_q[w][i];
        f.dirty = dirty_q[w][i];
        f.tag   = tag_q[w][i];
        f.data  = data_q[w][i];
        return f;
    endfunction

    // tag compare on both ways
    always_comb begin
        for (int w = 0; w < NWAYS; w++) begin
            way_hit[w] = valid_q[w][lookup_addr.idx] &&
                         (tag_q[w][lookup_addr.idx] == lookup_addr.tag);
        end
    end

    assign hit_way = way_hit[1];  // way 0 unless way 1 matched

    always_comb begin
        frame_t hit_frame;
        hit_frame          = get_frame(hit_way, lookup_addr.idx);
        lookup.hit         = |way_hit;
        lookup.hit_way     = hit_way;
        lookup.hit_word    = hit_frame.data[lookup_addr.blkoff];
        lookup.victim_way  = lru_q[lookup_addr.idx];
        lookup.victim      = get_frame(lru_q[lookup_addr.idx], lookup_addr.idx);
    end

    always_comb begin
        scan_frame = get_frame(scan_way, scan_idx);
    end

    // an idle command that names the way just hit counts as a read of that frame
    assign read_use = (cmd.op == NONE) && lookup.hit && (cmd.way == hit_way);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            case (cmd.op)
                WRITE_WORD: begin
                    dirty_q[cmd.way][cmd.idx] <= 1'b1;
                    lru_q[cmd.idx]            <= ~cmd.way;
                end
                FILL_WORD: begin
                    if (cmd.word_sel == '1) begin  // last word completes the frame
                        valid_q[cmd.way][cmd.idx] <= 1'b1;
                        dirty_q[cmd.way][cmd.idx] <= 1'b0;
                    end
                end
                CLEAN: begin
                    dirty_q[cmd.way][cmd.idx] <= 1'b0;
                end
                default: begin
                    if (read_use) begin
                        lru_q[cmd.idx] <= ~cmd.way;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (cmd.op == WRITE_WORD || cmd.op == FILL_WORD) begin
            data_q[cmd.way][cmd.idx][cmd.word_sel] <= cmd.data;
        end
        if (cmd.op == FILL_WORD && cmd.word_sel == '1) begin
            tag_q[cmd.way][cmd.idx] <= cmd.tag;
        end
    end

endmodule

`default_nettype wire

/* verilog/dcache_bus_pkg.sv */
`default_nettype none

package dcache_bus_pkg;

    import dcache_geom_pkg::*;

    // datapath side, held until hit
    typedef struct packed {
        logic  ren;
        logic  wen;
        logic  halt;
        addr_t addr;
        word_t store;
    } dp_req_t;

    typedef struct packed {
        logic  hit;
        word_t load;
        logic  flushed;
    } dp_rsp_t;

    // memory side, one word per transfer
    typedef struct packed {
        logic  ren;
        logic  wen;
        addr_t addr;
        word_t store;
    } mem_req_t;

    typedef struct packed {
        logic  busy;  // request held while high
        word_t load;
    } mem_rsp_t;

    typedef enum logic [3:0] {
        IDLE, WB1, WB2, LD1, LD2, SCAN, FLUSH1, FLUSH2, HALTED
    } ctrl_state_t;

    typedef enum logic [1:0] {
        NONE, WRITE_WORD, FILL_WORD, CLEAN
    } frame_op_t;

    // update for the frame store, applied at the next edge
    typedef struct packed {
        frame_op_t        op;
        logic [IDX_W-1:0] idx;
        way_t             way;
        logic [BLK_W-1:0] word_sel;
        logic [TAG_W-1:0] tag;
        word_t            data;
    } frame_cmd_t;

    typedef struct packed {
        logic   hit;
        way_t   hit_way;
        word_t  hit_word;
        way_t   victim_way;
        frame_t victim;
    } lookup_t;

endpackage

`default_nettype wire

/* verilog/dcache_geom_pkg.sv */
`default_nettype none

package dcache_geom_pkg;

    // word and frame shape
    localparam int WORD_W          = 32;
    localparam int WORDS_PER_FRAME = 2;
    localparam int BYT_W           = 2;                        // bytes within a word
    localparam int BLK_W           = $clog2(WORDS_PER_FRAME);  // word within a frame

    // set organisation
    localparam int IDX_W = 3;
    localparam int NSETS = 1 << IDX_W;
    localparam int NWAYS = 2;

    // what is left of the address
    localparam int TAG_W = WORD_W - IDX_W - BLK_W - BYT_W;

    typedef logic [WORD_W-1:0] word_t;

    typedef logic way_t;  // 0 or 1

    // byte address as the cache splits it
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] idx;
        logic [BLK_W-1:0] blkoff;
        logic [BYT_W-1:0] bytoff;
    } addr_t;

    // one way of one set
    typedef struct packed {
        logic                        valid;
        logic                        dirty;
        logic [TAG_W-1:0]            tag;
        word_t [WORDS_PER_FRAME-1:0] data;
    } frame_t;

endpackage

`default_nettype wire
